// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

  // cache geometry
  localparam int LINE_WORDS = 4;
  localparam int OFFSET_BITS = 2;
  localparam int INDEX_BITS = 4;
  localparam int WORD_INDEX_BITS = INDEX_BITS + OFFSET_BITS;

  // byte address field positions
  localparam int INDEX_LSB = OFFSET_BITS + 2;
  localparam int TAG_LSB = INDEX_LSB + INDEX_BITS;

  // physical address bits 28 down to TAG_LSB
  localparam int TAG_BITS = 29 - TAG_LSB;
  localparam int BUS_ADDR_BITS = TAG_BITS + INDEX_BITS + OFFSET_BITS;

  typedef enum logic [1:0] {
    WIDTH_BYTE = 2'b00,
    WIDTH_HALF = 2'b01,
    WIDTH_WORD = 2'b10
  } width_t;

  typedef struct packed {
    logic valid;
    logic dirty;
  } line_flags_t;

  typedef enum logic [5:0] {
    IDLE      = 6'b000001,
    EVICT     = 6'b000010,
    FILL_CMD  = 6'b000100,
    FILL_DATA = 6'b001000,
    COMMIT    = 6'b010000,
    ISSUE     = 6'b100000
  } miss_state_t;

  typedef struct packed {
    logic        read;
    logic        write;
    logic        extend;
    width_t      width;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

endpackage

// ==== verilog/mem_bus_if.sv ====
`timescale 1ns/10ps

interface mem_bus_if;

  // command channel
  logic                                 cvalid;
  logic                                 cready;
  logic                                 cmd;
  logic [dcache_pkg::BUS_ADDR_BITS-1:0] addr;

  // write channel
  logic                                 wvalid;
  logic                                 wready;
  logic                                 wlast;
  logic [31:0]                          wdata;

  // read channel
  logic                                 rvalid;
  logic                                 rready;
  logic                                 rlast;
  logic [31:0]                          rdata;

  // held high by the bus for as long as the fault lasts
  logic                                 error;

  modport master (
    output cvalid, cmd, addr, wvalid, wlast, wdata, rready,
    input  cready, wready, rvalid, rlast, rdata, error
  );

  modport top (
    input  cvalid, cmd, addr, wvalid, wlast, wdata, rready,
    output cready, wready, rvalid, rlast, rdata, error
  );

endinterface

// ==== verilog/line_store_if.sv ====
`timescale 1ns/10ps

interface line_store_if;

  // word address within the store, line index above word offset
  logic [dcache_pkg::WORD_INDEX_BITS-1:0] read_index;
  logic [dcache_pkg::TAG_BITS-1:0]        read_tag;
  dcache_pkg::line_flags_t                read_flags;
  logic [31:0]                            read_data;
  logic                                   hit;

  logic [dcache_pkg::WORD_INDEX_BITS-1:0] write_index;
  logic                                   write_data_req;
  logic [31:0]                            write_data;
  logic [3:0]                             write_mask;

  // write_tag is also the tag looked up for hit
  logic                                   write_tag_req;
  logic [dcache_pkg::TAG_BITS-1:0]        write_tag;
  dcache_pkg::line_flags_t                write_flags;

  modport ctrl (
    output read_index, write_index, write_data_req, write_data, write_mask,
    output write_tag_req, write_tag, write_flags,
    input  read_tag, read_flags, read_data, hit
  );

  modport store (
    input  read_index, write_index, write_data_req, write_data, write_mask,
    input  write_tag_req, write_tag, write_flags,
    output read_tag, read_flags, read_data, hit
  );

endinterface

// ==== verilog/line_store.sv ====
`timescale 1ns/10ps

module line_store (
  input logic         clk_core,
  input logic         reset_n,
  line_store_if.store port
);

  localparam int LINES = 2 ** dcache_pkg::INDEX_BITS;
  localparam int WORDS = dcache_pkg::LINE_WORDS * LINES;

  logic [dcache_pkg::TAG_BITS-1:0]   tags [LINES];
  dcache_pkg::line_flags_t           flags [LINES];
  logic [31:0]                       data [WORDS];

  logic [dcache_pkg::INDEX_BITS-1:0] read_line;
  logic [dcache_pkg::INDEX_BITS-1:0] write_line;

  assign read_line = port.read_index[dcache_pkg::OFFSET_BITS +: dcache_pkg::INDEX_BITS];
  assign write_line = port.write_index[dcache_pkg::OFFSET_BITS +: dcache_pkg::INDEX_BITS];

  // zero-latency lookup
  assign port.read_tag = tags[read_line];
  assign port.read_flags = flags[read_line];
  assign port.read_data = data[port.read_index];
  assign port.hit = flags[read_line].valid && (tags[read_line] == port.write_tag);

  always_ff @(posedge clk_core) begin
    if (!reset_n) begin
      for (int i = 0; i < LINES; i++) begin
        flags[i] <= '0;
      end
    end else if (port.write_tag_req) begin
      flags[write_line] <= port.write_flags;
    end
  end

  always_ff @(posedge clk_core) begin
    if (port.write_tag_req) begin
      tags[write_line] <= port.write_tag;
    end
  end

  // byte lanes merge under the mask
  always_ff @(posedge clk_core) begin
    if (port.write_data_req) begin
      for (int b = 0; b < 4; b++) begin
        if (port.write_mask[b]) begin
          data[port.write_index][8*b +: 8] <= port.write_data[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== verilog/beat_counter.sv ====
`timescale 1ns/10ps

module beat_counter (
  input  logic                               clk_core,
  input  logic                               reset_n,
  input  logic                               beat,
  input  logic [dcache_pkg::OFFSET_BITS-1:0] want_offset,
  output logic [dcache_pkg::OFFSET_BITS-1:0] offset,
  output logic                               last_beat,
  output logic                               wanted_word
);

  always_ff @(posedge clk_core) begin
    if (!reset_n) begin
      offset <= '0;
    end else if (beat) begin
      // rolls back to word 0 after the last beat
      offset <= offset + 1'b1;
    end
  end

  assign last_beat = (int'(offset) == dcache_pkg::LINE_WORDS - 1);

  // beat carrying the requested word
  assign wanted_word = (offset == want_offset);

endmodule

// ==== verilog/lane_align.sv ====
`timescale 1ns/10ps

module lane_align (
  input  dcache_pkg::mem_req_t req,
  input  logic [31:0]          word_in,
  output logic [31:0]          store_data,
  output logic [3:0]           store_mask,
  output logic [31:0]          load_data
);

  logic [1:0]  lane;
  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  assign lane = req.addr[1:0];
  assign lane_byte = word_in[8*lane +: 8];
  assign lane_half = word_in[16*lane[1] +: 16];

  // place store bytes in their lane
  always_comb begin
    store_data = '0;
    store_mask = '0;
    case (req.width)
      dcache_pkg::WIDTH_BYTE: begin
        store_data[8*lane +: 8] = req.wdata[7:0];
        store_mask[lane] = 1'b1;
      end
      dcache_pkg::WIDTH_HALF: begin
        store_data[16*lane[1] +: 16] = req.wdata[15:0];
        store_mask[2*lane[1] +: 2] = 2'b11;
      end
      default: begin
        store_data = req.wdata;
        store_mask = 4'hf;
      end
    endcase
  end

  // pick load lane, zero or sign extend
  always_comb begin
    load_data = '0;
    if (req.read) begin
      case (req.width)
        dcache_pkg::WIDTH_BYTE:
          load_data = {{24{req.extend & lane_byte[7]}}, lane_byte};
        dcache_pkg::WIDTH_HALF:
          load_data = {{16{req.extend & lane_half[15]}}, lane_half};
        dcache_pkg::WIDTH_WORD:
          load_data = word_in;
        default:
          load_data = '0;
      endcase
    end
  end

endmodule

// ==== verilog/miss_fsm.sv ====
`timescale 1ns/10ps

module miss_fsm (
  input  logic                               clk_core,
  input  logic                               reset_n,
  input  dcache_pkg::mem_req_t               req,
  input  logic                               active,
  mem_bus_if.master                          bus,
  line_store_if.ctrl                         cache,
  input  logic [dcache_pkg::OFFSET_BITS-1:0] offset,
  input  logic                               last_beat,
  input  logic                               wanted_word,
  output logic                               beat,
  input  logic [31:0]                        store_data,
  input  logic [3:0]                         store_mask,
  output logic [31:0]                        word_out,
  output logic                               done,
  output logic                               error
);

  dcache_pkg::miss_state_t             state;
  dcache_pkg::miss_state_t             state_next;

  logic [dcache_pkg::INDEX_BITS-1:0]   index;
  logic [dcache_pkg::OFFSET_BITS-1:0]  req_offset;
  logic                                capture;
  logic [31:0]                         rword;

  assign index = req.addr[dcache_pkg::INDEX_LSB +: dcache_pkg::INDEX_BITS];
  assign req_offset = req.addr[2 +: dcache_pkg::OFFSET_BITS];

  assign cache.write_tag = req.addr[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_BITS];
  assign cache.read_index = {index, (state == dcache_pkg::EVICT) ? offset : req_offset};

  // victim words go straight from the store onto the bus
  assign bus.wdata = cache.read_data;

  assign beat = (bus.wvalid & bus.wready) | (bus.rvalid & bus.rready);
  assign error = active & bus.error;

  always_ff @(posedge clk_core) begin
    if (!reset_n || bus.error) begin
      state <= dcache_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk_core) begin
    if (capture) begin
      rword <= bus.rdata;
    end
  end

  always_comb begin
    state_next = state;
    done = 1'b0;
    capture = 1'b0;
    word_out = cache.read_data;

    bus.cvalid = 1'b0;
    bus.cmd = 1'b0;
    bus.addr = {cache.write_tag, index, {dcache_pkg::OFFSET_BITS{1'b0}}};
    bus.wvalid = 1'b0;
    bus.wlast = 1'b0;
    bus.rready = 1'b0;

    cache.write_index = {index, req_offset};
    cache.write_data_req = 1'b0;
    cache.write_data = store_data;
    cache.write_mask = store_mask;
    cache.write_tag_req = 1'b0;
    cache.write_flags = '0;

    case (state)
      dcache_pkg::IDLE: begin
        if (active) begin
          if (cache.hit) begin
            done = 1'b1;
            if (req.write) begin
              cache.write_data_req = 1'b1;
              cache.write_tag_req = 1'b1;
              cache.write_flags = '{valid: 1'b1, dirty: 1'b1};
            end
          end else if (cache.read_flags.valid && cache.read_flags.dirty) begin
            // write command for the victim held until taken
            bus.cvalid = 1'b1;
            bus.addr = {cache.read_tag, index, {dcache_pkg::OFFSET_BITS{1'b0}}};
            if (bus.cready) begin
              state_next = dcache_pkg::EVICT;
            end
          end else begin
            // drop the old line so a broken fill leaves nothing valid
            cache.write_tag_req = 1'b1;
            state_next = dcache_pkg::FILL_CMD;
          end
        end
      end

      dcache_pkg::EVICT: begin
        bus.wvalid = 1'b1;
        bus.wlast = last_beat;
        if (bus.wready && last_beat) begin
          cache.write_tag_req = 1'b1;
          state_next = dcache_pkg::FILL_CMD;
        end
      end

      dcache_pkg::FILL_CMD: begin
        bus.cvalid = 1'b1;
        bus.cmd = 1'b1;
        if (bus.cready) begin
          state_next = dcache_pkg::FILL_DATA;
        end
      end

      dcache_pkg::FILL_DATA: begin
        bus.rready = 1'b1;
        if (bus.rvalid) begin
          cache.write_index = {index, offset};
          cache.write_data_req = 1'b1;
          cache.write_data = bus.rdata;
          cache.write_mask = 4'hf;
          capture = wanted_word;
          if (bus.rlast) begin
            cache.write_tag_req = 1'b1;
            cache.write_flags = '{valid: 1'b1, dirty: 1'b0};
            state_next = dcache_pkg::COMMIT;
          end
        end
      end

      dcache_pkg::COMMIT: begin
        if (req.write) begin
          cache.write_data_req = 1'b1;
          cache.write_tag_req = 1'b1;
          cache.write_flags = '{valid: 1'b1, dirty: 1'b1};
        end
        state_next = dcache_pkg::ISSUE;
      end

      dcache_pkg::ISSUE: begin
        done = 1'b1;
        word_out = rword;
        state_next = dcache_pkg::IDLE;
      end

      default: begin
        state_next = dcache_pkg::IDLE;
      end
    endcase

    // bus fault ends the access
    if (error) begin
      done = 1'b1;
    end
  end

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage (
  input  logic                                 clk_core,
  input  logic                                 reset_n,
  input  logic                                 req_valid,
  input  logic                                 req_read,
  input  logic                                 req_write,
  input  logic                                 req_extend,
  input  dcache_pkg::width_t                   req_width,
  input  logic [31:0]                          req_addr,
  input  logic [31:0]                          req_wdata,
  output logic                                 stall,
  output logic                                 resp_valid,
  output logic                                 resp_error,
  output logic [31:0]                          resp_rdata,
  output logic                                 cvalid,
  input  logic                                 cready,
  output logic                                 cmd,
  output logic [dcache_pkg::BUS_ADDR_BITS-1:0] bus_addr,
  output logic                                 wvalid,
  input  logic                                 wready,
  output logic                                 wlast,
  output logic [31:0]                          bus_wdata,
  input  logic                                 rvalid,
  output logic                                 rready,
  input  logic                                 rlast,
  input  logic [31:0]                          rdata,
  input  logic                                 bus_error,
  output logic                                 eack
);

  mem_bus_if    bus_if ();
  line_store_if cache_if ();

  dcache_pkg::mem_req_t               req_q;
  logic                               req_valid_q;
  logic                               done;
  logic                               beat;
  logic                               count_reset_n;
  logic [dcache_pkg::OFFSET_BITS-1:0] offset;
  logic                               last_beat;
  logic                               wanted_word;
  logic [31:0]                        store_data;
  logic [3:0]                         store_mask;
  logic [31:0]                        word_out;

  assign bus_if.cready = cready;
  assign bus_if.wready = wready;
  assign bus_if.rvalid = rvalid;
  assign bus_if.rlast = rlast;
  assign bus_if.rdata = rdata;
  assign bus_if.error = bus_error;

  assign cvalid = bus_if.cvalid;
  assign cmd = bus_if.cmd;
  assign bus_addr = bus_if.addr;
  assign wvalid = bus_if.wvalid;
  assign wlast = bus_if.wlast;
  assign bus_wdata = bus_if.wdata;
  assign rready = bus_if.rready;
  assign eack = bus_if.error;

  // stage register
  always_ff @(posedge clk_core) begin
    if (!reset_n) begin
      req_valid_q <= 1'b0;
    end else if (!stall) begin
      req_valid_q <= req_valid;
    end
  end

  always_ff @(posedge clk_core) begin
    if (!stall && req_valid) begin
      req_q <= '{read: req_read, write: req_write, extend: req_extend, width: req_width,
                 addr: req_addr, wdata: req_wdata};
    end
  end

  assign stall = req_valid_q & ~done;
  assign resp_valid = done;

  // a bus fault abandons the burst, restart at word 0
  assign count_reset_n = reset_n & ~bus_error;

  line_store line_store_inst (
    .clk_core (clk_core),
    .reset_n  (reset_n),
    .port     (cache_if.store)
  );

  beat_counter beat_counter_inst (
    .clk_core    (clk_core),
    .reset_n     (count_reset_n),
    .beat        (beat),
    .want_offset (req_q.addr[2 +: dcache_pkg::OFFSET_BITS]),
    .offset      (offset),
    .last_beat   (last_beat),
    .wanted_word (wanted_word)
  );

  lane_align lane_align_inst (
    .req        (req_q),
    .word_in    (word_out),
    .store_data (store_data),
    .store_mask (store_mask),
    .load_data  (resp_rdata)
  );

  miss_fsm miss_fsm_inst (
    .clk_core    (clk_core),
    .reset_n     (reset_n),
    .req         (req_q),
    .active      (req_valid_q),
    .bus         (bus_if.master),
    .cache       (cache_if.ctrl),
    .offset      (offset),
    .last_beat   (last_beat),
    .wanted_word (wanted_word),
    .beat        (beat),
    .store_data  (store_data),
    .store_mask  (store_mask),
    .word_out    (word_out),
    .done        (done),
    .error       (resp_error)
  );

endmodule

// ==== verification/mem_stage_assertions.sv ====
`timescale 1ns/10ps

module mem_stage_assertions (
  input logic clk_core,
  input logic reset_n,
  input logic cvalid,
  input logic cready,
  input logic wvalid,
  input logic wlast,
  input logic stall,
  input logic resp_valid
);

  int failures = 0;

  // command held until the bus takes it
  cvalid_held: assert property (@(posedge clk_core) disable iff (!reset_n)
    cvalid && !cready |=> cvalid)
  else begin
    failures++;
    $error("cvalid dropped before cready");
  end

  wlast_with_wvalid: assert property (@(posedge clk_core) disable iff (!reset_n)
    wlast |-> wvalid)
  else begin
    failures++;
    $error("wlast high without wvalid");
  end

  // first cycle out of reset
  quiet_after_reset: assert property (@(posedge clk_core)
    $rose(reset_n) |-> !stall && !resp_valid)
  else begin
    failures++;
    $error("stall or resp_valid high right after reset");
  end

  resp_single_cycle: assert property (@(posedge clk_core) disable iff (!reset_n)
    resp_valid |=> !resp_valid)
  else begin
    failures++;
    $error("resp_valid high for two cycles");
  end

endmodule

// ==== verification/tb_mem_stage.sv ====
`timescale 1ns/10ps

module tb_mem_stage;

  localparam int TIMEOUT = 200;
  localparam int MEM_WORDS = 1024;
  localparam logic LD = 1'b0;
  localparam logic ST = 1'b1;
  localparam dcache_pkg::width_t BYTE = dcache_pkg::WIDTH_BYTE;
  localparam dcache_pkg::width_t HALF = dcache_pkg::WIDTH_HALF;
  localparam dcache_pkg::width_t WORD = dcache_pkg::WIDTH_WORD;

  typedef struct packed {
    logic               store;
    dcache_pkg::width_t width;
    logic               extend;
    logic [31:0]        addr;
    logic [31:0]        wdata;
    logic [31:0]        rdata;
    logic               error;
    logic               hit;
  } entry_t;

  logic clk_core = 1'b0;
  logic reset_n;
  logic req_valid, req_read, req_write, req_extend;
  dcache_pkg::width_t req_width;
  logic [31:0] req_addr, req_wdata;
  logic stall, resp_valid, resp_error;
  logic [31:0] resp_rdata;
  logic cvalid, cready, cmd;
  logic [dcache_pkg::BUS_ADDR_BITS-1:0] bus_addr;
  logic wvalid, wready, wlast;
  logic [31:0] bus_wdata;
  logic rvalid, rready, rlast;
  logic [31:0] rdata;
  logic bus_error, eack;

  entry_t entries[$];
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] lfsr = 32'h67fa;
  logic random_delays = 1'b0;
  logic inject_error = 1'b0;
  int mismatch_errors = 0;
  int protocol_errors = 0;
  int timeout_errors = 0;
  int assertion_errors;

  // bus model state
  logic in_reset, c_fire, w_fire, r_fire, c_seen, w_seen, c_cmd, w_last, rd_active;
  int c_addr, c_wait, w_wait, r_wait, rd_base, wr_base, rd_beat, wr_beat;
  logic [31:0] w_data;

  always #10 clk_core = ~clk_core;

  mem_stage mem_stage_inst (.*);

  bind mem_stage mem_stage_assertions mem_stage_assertions_inst (.*);

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic int draw_delay();
    logic [1:0] d;
    d = '0;
    if (random_delays) begin
      for (int b = 0; b < 2; b++) begin
        d[b] = lfsr[0];
        lfsr = lfsr_next(lfsr);
      end
    end
    return int'(d);
  endfunction

  // bus memory model samples at negedge and drives after the rising edge
  always begin
    @(negedge clk_core);
    in_reset = !reset_n;
    c_fire = cvalid & cready;
    w_fire = wvalid & wready;
    r_fire = rvalid & rready;
    c_seen = cvalid;
    w_seen = wvalid;
    c_cmd = cmd;
    c_addr = int'(bus_addr);
    w_data = bus_wdata;
    w_last = wlast;
    @(posedge clk_core);
    #1;
    bus_error = 1'b0;
    if (in_reset) begin
      rd_active = 1'b0;
      rd_beat = 0;
      wr_beat = 0;
      c_wait = 0;
      w_wait = 0;
      r_wait = 0;
    end else begin
      if (c_fire) begin
        assert (c_addr + 4 <= MEM_WORDS) else begin
          protocol_errors++;
          $display("bus address %h at %0t is outside the memory model", c_addr, $time);
        end
        if (c_cmd) begin
          rd_base = c_addr;
          rd_beat = 0;
          rd_active = 1'b1;
        end else begin
          wr_base = c_addr;
          wr_beat = 0;
        end
        c_wait = draw_delay();
      end else if (c_seen && c_wait != 0) begin
        c_wait--;
      end
      if (w_fire) begin
        // last write beat of the line is beat 3
        assert (w_last == (wr_beat == 3)) else begin
          mismatch_errors++;
          $display("mismatch at %0t: wlast = %b, expected %b", $time, w_last, wr_beat == 3);
        end
        if (wr_beat < 4) begin
          mem[wr_base + wr_beat] = w_data;
        end
        wr_beat++;
        w_wait = draw_delay();
      end else if (w_seen && w_wait != 0) begin
        w_wait--;
      end
      if (r_fire) begin
        rd_beat++;
        if (rd_beat == 4) begin
          rd_active = 1'b0;
        end
        r_wait = draw_delay();
      end else if (rd_active && r_wait != 0) begin
        r_wait--;
      end
      // fault in the middle of a fill
      if (inject_error && rd_active && rd_beat == 2) begin
        bus_error = 1'b1;
        rd_active = 1'b0;
        inject_error = 1'b0;
      end
    end
    cready = !in_reset && (c_wait == 0);
    wready = !in_reset && (w_wait == 0);
    rvalid = rd_active && (r_wait == 0);
    rlast = rd_active && (rd_beat == 3);
    rdata = rd_active ? mem[rd_base + rd_beat] : '0;
  end

  task automatic fill_memory();
    for (int w = 0; w < MEM_WORDS; w++) begin
      mem[w] = 32'(w) ^ 32'h5a5a_0000;
    end
  endtask

  task automatic apply_reset();
    reset_n = 1'b0;
    fill_memory();
    repeat (4) @(posedge clk_core);
    #1;
    reset_n = 1'b1;
  endtask

  task automatic add_entry(input logic store, input dcache_pkg::width_t width,
                           input logic extend, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] rdata,
                           input logic error, input logic hit);
    entries.push_back({store, width, extend, addr, wdata, rdata, error, hit});
  endtask

  task automatic build_table();
    // op, width, extend, byte address, write data, expected rdata, bus error, hit
    add_entry(LD, WORD, 0, 32'h0000_0110, 32'h0, 32'h5a5a_0044, 0, 0);
    add_entry(LD, BYTE, 0, 32'h0000_0112, 32'h0, 32'h0000_005a, 0, 1);
    add_entry(LD, WORD, 0, 32'h0000_02f4, 32'h0, 32'h5a5a_00bd, 0, 0);
    add_entry(LD, BYTE, 1, 32'h0000_02f4, 32'h0, 32'hffff_ffbd, 0, 1);
    add_entry(LD, BYTE, 0, 32'h0000_02f4, 32'h0, 32'h0000_00bd, 0, 1);
    add_entry(LD, HALF, 0, 32'h0000_02f6, 32'h0, 32'h0000_5a5a, 0, 1);
    add_entry(LD, HALF, 1, 32'h0000_02f4, 32'h0, 32'h0000_00bd, 0, 1);
    add_entry(ST, HALF, 0, 32'h0000_02f6, 32'h0000_c3a5, 32'h0, 0, 1);
    add_entry(LD, HALF, 1, 32'h0000_02f6, 32'h0, 32'hffff_c3a5, 0, 1);
    add_entry(LD, BYTE, 1, 32'h0000_02f7, 32'h0, 32'hffff_ffc3, 0, 1);
    add_entry(LD, WORD, 0, 32'h0000_02f4, 32'h0, 32'hc3a5_00bd, 0, 1);
    add_entry(ST, BYTE, 0, 32'h0000_02f9, 32'h0000_0077, 32'h0, 0, 1);
    add_entry(LD, WORD, 0, 32'h0000_02f8, 32'h0, 32'h5a5a_77be, 0, 1);
    add_entry(ST, WORD, 0, 32'h0000_02fc, 32'h1234_5678, 32'h0, 0, 1);
    add_entry(LD, WORD, 0, 32'h0000_02fc, 32'h0, 32'h1234_5678, 0, 1);
    add_entry(ST, BYTE, 0, 32'h0000_01a3, 32'h0000_0099, 32'h0, 0, 0);
    add_entry(LD, WORD, 0, 32'h0000_01a0, 32'h0, 32'h995a_0068, 0, 1);
    // same index with another tag sends the dirty line back to memory
    add_entry(LD, WORD, 0, 32'h0000_03f0, 32'h0, 32'h5a5a_00fc, 0, 0);
    add_entry(LD, WORD, 0, 32'h0000_02f4, 32'h0, 32'hc3a5_00bd, 0, 0);
    add_entry(LD, WORD, 0, 32'h0000_02f8, 32'h0, 32'h5a5a_77be, 0, 1);
    add_entry(LD, WORD, 0, 32'h0000_02fc, 32'h0, 32'h1234_5678, 0, 1);
    add_entry(LD, WORD, 0, 32'h0000_0150, 32'h0, 32'h0, 1, 0);
    add_entry(LD, WORD, 0, 32'h0000_0150, 32'h0, 32'h5a5a_0054, 0, 0);
  endtask

  task automatic run_entry(input entry_t t);
    int cycles;
    logic accepted;
    logic responded;
    logic [31:0] got_rdata;
    logic got_error;
    logic got_eack;
    req_valid = 1'b1;
    req_read = !t.store;
    req_write = t.store;
    req_extend = t.extend;
    req_width = t.width;
    req_addr = t.addr;
    req_wdata = t.wdata;
    inject_error = t.error;
    cycles = 0;
    accepted = 1'b0;
    while (!accepted && cycles < TIMEOUT) begin
      @(negedge clk_core);
      accepted = !stall;
      cycles++;
    end
    if (!accepted) begin
      timeout_errors++;
      $display("request to %h at %0t was never accepted", t.addr, $time);
      return;
    end
    @(posedge clk_core);
    #1;
    req_valid = 1'b0;
    cycles = 0;
    responded = 1'b0;
    while (!responded && cycles < TIMEOUT) begin
      @(negedge clk_core);
      cycles++;
      assert (stall == !resp_valid) else begin
        protocol_errors++;
        $display("stall is %b with resp_valid %b at %0t", stall, resp_valid, $time);
      end
      if (resp_valid) begin
        responded = 1'b1;
        got_rdata = resp_rdata;
        got_error = resp_error;
        got_eack = eack;
      end
    end
    if (!responded) begin
      timeout_errors++;
      $display("no response for access to %h at %0t", t.addr, $time);
      return;
    end
    assert ((cycles == 1) == t.hit) else begin
      protocol_errors++;
      $display("access to %h took %0d cycles, hit expected %b", t.addr, cycles, t.hit);
    end
    assert (got_error == t.error) else begin
      mismatch_errors++;
      $display("mismatch at %0t: resp_error = %b, expected %b", $time, got_error, t.error);
    end
    assert (got_eack == t.error) else begin
      mismatch_errors++;
      $display("mismatch at %0t: eack = %b, expected %b", $time, got_eack, t.error);
    end
    if (!t.store && !t.error) begin
      assert (got_rdata == t.rdata) else begin
        mismatch_errors++;
        $display("mismatch at %0t: resp_rdata = %h, expected %h", $time, got_rdata, t.rdata);
      end
    end
    @(posedge clk_core);
    #1;
  endtask

  initial begin
    reset_n = 1'b0;
    req_valid = 1'b0;
    req_read = 1'b0;
    req_write = 1'b0;
    req_extend = 1'b0;
    req_width = dcache_pkg::WIDTH_WORD;
    req_addr = '0;
    req_wdata = '0;
    cready = 1'b0;
    wready = 1'b0;
    rvalid = 1'b0;
    rlast = 1'b0;
    rdata = '0;
    bus_error = 1'b0;
    build_table();
    // second pass repeats the table under random back-pressure
    for (int pass = 0; pass < 2; pass++) begin
      random_delays = (pass == 1);
      apply_reset();
      foreach (entries[i]) begin
        run_entry(entries[i]);
        if (timeout_errors != 0) begin
          break;
        end
      end
      if (timeout_errors != 0) begin
        break;
      end
    end
    assertion_errors = mem_stage_inst.mem_stage_assertions_inst.failures;
    $display("error counts: mismatch %0d, protocol %0d, timeout %0d, assertion %0d",
             mismatch_errors, protocol_errors, timeout_errors, assertion_errors);
    if (mismatch_errors + protocol_errors + timeout_errors + assertion_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
verilog/dcache_pkg.sv
verilog/mem_bus_if.sv
verilog/line_store_if.sv
verilog/line_store.sv
verilog/beat_counter.sv
verilog/lane_align.sv
verilog/miss_fsm.sv
verilog/mem_stage.sv
verification/mem_stage_assertions.sv
verification/tb_mem_stage.sv
